//--- include/alloc_defs.svh
// ----------------------------------------------------------
// sizing constants for the 2x2 mesh path allocator
// the route table and router coordinates assume 4 nodes,
// so NUM_NODES and DEST_W are fixed
// ----------------------------------------------------------
`ifndef ALLOC_DEFS_SVH
`define ALLOC_DEFS_SVH

// processor nodes, one router each
`define NUM_NODES 4

// router output ports: processor, west, east, south, north
`define NUM_PORTS 5

// width of an input select code
`define SEL_W 3

// bits of path_free, one per fixed route in the mesh
`define NUM_PATHS 28

// destination node index width
`define DEST_W 2

`endif

//--- verilog/noc_alloc_pkg.sv
// ----------------------------------------------------------
// types shared by the route tables, arbiters and control register
// port and select encodings match the router datapath
// router_sel_t and port_mask_t are indexed by port_e
// ----------------------------------------------------------
`default_nettype none

`include "alloc_defs.svh"

package noc_alloc_pkg;

    localparam int PATH_W = $clog2(`NUM_PATHS);

    // output port index inside one router
    typedef enum logic [2:0]
    {
        PORT_PROC  = 3'd0,
        PORT_WEST  = 3'd1,
        PORT_EAST  = 3'd2,
        PORT_SOUTH = 3'd3,
        PORT_NORTH = 3'd4
    } port_e;

    // which input feeds an output port
    typedef enum logic [`SEL_W-1:0]
    {
        SEL_NORTH = 3'b000,
        SEL_SOUTH = 3'b001,
        SEL_EAST  = 3'b010,
        SEL_WEST  = 3'b011,
        SEL_PROC  = 3'b100
    } sel_e;

    typedef logic [`NUM_PORTS-1:0] port_mask_t;
    typedef port_mask_t [`NUM_NODES-1:0] mesh_mask_t;  // router 0 lowest
    typedef sel_e [`NUM_PORTS-1:0] router_sel_t;

    typedef struct packed
    {
        logic                        valid;
        logic [PATH_W-1:0]           path;   // bit of path_free
        mesh_mask_t                  claim;
        router_sel_t [`NUM_NODES-1:0] sel;
    } route_t;

    typedef struct packed
    {
        logic                        granted;
        mesh_mask_t                  claim;  // zero when not granted
        router_sel_t [`NUM_NODES-1:0] sel;
    } grant_t;

endpackage

`default_nettype wire

//--- verilog/route_if.sv
// ----------------------------------------------------------
// primary and alternate route candidates, table to arbiter
// purely combinational, no handshake
// alternate.valid is low for a route to the node itself
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface route_if;

    noc_alloc_pkg::route_t primary;
    noc_alloc_pkg::route_t alternate;

    // route table side
    modport tbl
    (
        output primary,
        output alternate
    );

    modport arbiter
    (
        input primary,
        input alternate
    );

endinterface

`default_nettype wire

//--- verilog/route_rom.sv
// ----------------------------------------------------------
// fixed routes from one source node, primary and alternate
// node 0 south-west, 1 south-east, 2 north-west, 3 north-east
// a route is listed as the routers it passes, source first;
// ports and selects follow from the mesh coordinates
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "alloc_defs.svh"

module route_rom #(
    parameter int SRC = 0
) (
    input wire logic [`DEST_W-1:0] dest,
    route_if.tbl                   routes
);

    localparam logic [`DEST_W-1:0] SRC_ID = SRC[`DEST_W-1:0];

    logic [2*`DEST_W-1:0] key;

    assign key = {SRC_ID, dest};

    // n routers in hops, first router in the top two bits
    function automatic noc_alloc_pkg::route_t walk(
        input logic [noc_alloc_pkg::PATH_W-1:0] path,
        input int                               n,
        input logic [7:0]                       hops
    );
        noc_alloc_pkg::route_t r;
        noc_alloc_pkg::sel_e   in_sel;
        noc_alloc_pkg::port_e  out;
        logic [7:0]            h;
        logic [1:0]            cur;
        logic [1:0]            nxt;
        r = '0;
        r.valid = 1'b1;
        r.path = path;
        h = hops;
        in_sel = noc_alloc_pkg::SEL_PROC;   // traffic enters at the source processor
        for (int i = 0; i < 4; i++)
        begin
            if (i < n)
            begin
                cur = h[7:6];
                nxt = h[5:4];
                h = h << 2;
                if (i == n - 1)
                    out = noc_alloc_pkg::PORT_PROC;
                else if (nxt[0] != cur[0])  // bit 0 is x, bit 1 is y
                    out = nxt[0] ? noc_alloc_pkg::PORT_EAST : noc_alloc_pkg::PORT_WEST;
                else
                    out = nxt[1] ? noc_alloc_pkg::PORT_NORTH : noc_alloc_pkg::PORT_SOUTH;
                r.claim[cur][out] = 1'b1;
                r.sel[cur][out] = in_sel;
                // next router sees us on the opposite side
                case (out)
                    noc_alloc_pkg::PORT_EAST:  in_sel = noc_alloc_pkg::SEL_WEST;
                    noc_alloc_pkg::PORT_WEST:  in_sel = noc_alloc_pkg::SEL_EAST;
                    noc_alloc_pkg::PORT_NORTH: in_sel = noc_alloc_pkg::SEL_SOUTH;
                    default:                   in_sel = noc_alloc_pkg::SEL_NORTH;
                endcase
            end
        end
        return r;
    endfunction

    always_comb
    begin
        // direct routes, along the shared edge where there is one
        case (key)
            4'h0: routes.primary = walk(5'd0, 1, {2'd0, 2'd0, 2'd0, 2'd0});
            4'h1: routes.primary = walk(5'd1, 2, {2'd0, 2'd1, 2'd0, 2'd0});
            4'h2: routes.primary = walk(5'd3, 2, {2'd0, 2'd2, 2'd0, 2'd0});
            4'h3: routes.primary = walk(5'd5, 3, {2'd0, 2'd2, 2'd3, 2'd0});
            4'h4: routes.primary = walk(5'd8, 2, {2'd1, 2'd0, 2'd0, 2'd0});
            4'h5: routes.primary = walk(5'd7, 1, {2'd1, 2'd0, 2'd0, 2'd0});
            4'h6: routes.primary = walk(5'd12, 3, {2'd1, 2'd3, 2'd2, 2'd0});
            4'h7: routes.primary = walk(5'd10, 2, {2'd1, 2'd3, 2'd0, 2'd0});
            4'h8: routes.primary = walk(5'd17, 2, {2'd2, 2'd0, 2'd0, 2'd0});
            4'h9: routes.primary = walk(5'd19, 3, {2'd2, 2'd3, 2'd1, 2'd0});
            4'ha: routes.primary = walk(5'd14, 1, {2'd2, 2'd0, 2'd0, 2'd0});
            4'hb: routes.primary = walk(5'd15, 2, {2'd2, 2'd3, 2'd0, 2'd0});
            4'hc: routes.primary = walk(5'd26, 3, {2'd3, 2'd1, 2'd0, 2'd0});
            4'hd: routes.primary = walk(5'd24, 2, {2'd3, 2'd1, 2'd0, 2'd0});
            4'he: routes.primary = walk(5'd22, 2, {2'd3, 2'd2, 2'd0, 2'd0});
            default: routes.primary = walk(5'd21, 1, {2'd3, 2'd0, 2'd0, 2'd0});
        endcase

        // the long way round
        case (key)
            4'h1: routes.alternate = walk(5'd2, 4, {2'd0, 2'd2, 2'd3, 2'd1});
            4'h2: routes.alternate = walk(5'd4, 4, {2'd0, 2'd1, 2'd3, 2'd2});
            4'h3: routes.alternate = walk(5'd6, 3, {2'd0, 2'd1, 2'd3, 2'd0});
            4'h4: routes.alternate = walk(5'd9, 4, {2'd1, 2'd3, 2'd2, 2'd0});
            4'h6: routes.alternate = walk(5'd13, 3, {2'd1, 2'd0, 2'd2, 2'd0});
            4'h7: routes.alternate = walk(5'd11, 4, {2'd1, 2'd0, 2'd2, 2'd3});
            4'h8: routes.alternate = walk(5'd18, 4, {2'd2, 2'd3, 2'd1, 2'd0});
            4'h9: routes.alternate = walk(5'd20, 3, {2'd2, 2'd0, 2'd1, 2'd0});
            4'hb: routes.alternate = walk(5'd16, 4, {2'd2, 2'd0, 2'd1, 2'd3});
            4'hc: routes.alternate = walk(5'd27, 3, {2'd3, 2'd2, 2'd0, 2'd0});
            4'hd: routes.alternate = walk(5'd25, 4, {2'd3, 2'd2, 2'd0, 2'd1});
            4'he: routes.alternate = walk(5'd23, 4, {2'd3, 2'd1, 2'd0, 2'd2});
            default: routes.alternate = '0;    // self routes have no alternate
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/path_arbiter.sv
// ----------------------------------------------------------
// route choice for one node in the fixed priority chain
// claimed_in holds ports taken by higher-priority nodes
// this cycle; a denied node claims nothing
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "alloc_defs.svh"

module path_arbiter (
    input  wire logic                    request,
    route_if.arbiter                     routes,
    input  wire logic [`NUM_PATHS-1:0]   path_free,
    input  wire noc_alloc_pkg::mesh_mask_t claimed_in,
    output noc_alloc_pkg::mesh_mask_t    claimed_out,
    output noc_alloc_pkg::grant_t        grant
);

    logic pri_ok;
    logic alt_ok;

    // free path and no port already taken upstream
    assign pri_ok = request && routes.primary.valid
                    && path_free[routes.primary.path]
                    && ((routes.primary.claim & claimed_in) == '0);

    assign alt_ok = request && routes.alternate.valid
                    && path_free[routes.alternate.path]
                    && ((routes.alternate.claim & claimed_in) == '0);

    always_comb
    begin
        grant = '0;
        if (pri_ok)
        begin
            grant.granted = 1'b1;
            grant.claim = routes.primary.claim;
            grant.sel = routes.primary.sel;
        end
        else if (alt_ok)    // fall back only when the direct route is blocked
        begin
            grant.granted = 1'b1;
            grant.claim = routes.alternate.claim;
            grant.sel = routes.alternate.sel;
        end
    end

    // pass the claims down to the next node
    assign claimed_out = claimed_in | grant.claim;

endmodule

`default_nettype wire

//--- verilog/router_ctrl_reg.sv
// ----------------------------------------------------------
// per-router control words from the four grants, registered
// unclaimed ports get select 000 and are inactive
// a circuit lives one cycle, nothing is held across cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "alloc_defs.svh"

module router_ctrl_reg (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire noc_alloc_pkg::grant_t [`NUM_NODES-1:0] grants,
    output noc_alloc_pkg::router_sel_t [`NUM_NODES-1:0] router_select,
    output noc_alloc_pkg::mesh_mask_t                  router_active,
    output logic [`NUM_NODES-1:0]                      response,
    output noc_alloc_pkg::mesh_mask_t                  port_free
);

    noc_alloc_pkg::mesh_mask_t                   active_next;
    noc_alloc_pkg::router_sel_t [`NUM_NODES-1:0] sel_next;
    noc_alloc_pkg::mesh_mask_t                   overlap;
    logic [`NUM_NODES-1:0]                       granted;

    always_comb
    begin
        active_next = '0;
        overlap = '0;
        sel_next = '0;
        for (int n = 0; n < `NUM_NODES; n++)
        begin
            overlap = overlap | (active_next & grants[n].claim);
            active_next = active_next | grants[n].claim;
            granted[n] = grants[n].granted;
            for (int r = 0; r < `NUM_NODES; r++)
            begin
                for (int p = 0; p < `NUM_PORTS; p++)
                begin
                    if (grants[n].claim[r][p])
                        sel_next[r][p] = grants[n].sel[r][p];
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            router_active <= '0;
            router_select <= '0;
            response <= '0;
            port_free <= '1;    // all ports free out of reset
        end
        else
        begin
            router_active <= active_next;
            router_select <= sel_next;
            response <= granted;
            port_free <= ~active_next;
        end
    end

    // the arbiter chain must never hand one port to two nodes
    a_claims_disjoint: assert property (
        @(posedge clock) disable iff (reset) overlap == '0
    ) else $error("router ports claimed by more than one grant");

    for (genvar n = 0; n < `NUM_NODES; n++)
    begin : g_grant_chk
        // every route ends on the destination processor port
        a_grant_claims: assert property (
            @(posedge clock) disable iff (reset) grants[n].granted |-> grants[n].claim != '0
        ) else $error("node %0d granted with an empty claim", n);
    end

endmodule

`default_nettype wire

//--- verilog/path_alloc_top.sv
// ----------------------------------------------------------
// circuit path allocator for the 2x2 mesh
// node 0 has the highest priority; outputs follow the
// sampled requests by one cycle and are valid for one cycle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "alloc_defs.svh"

module path_alloc_top (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic [`NUM_NODES-1:0]                 request,
    input  wire logic [`NUM_NODES-1:0][`DEST_W-1:0]    dest,
    input  wire logic [`NUM_PATHS-1:0]                 path_free,
    output noc_alloc_pkg::router_sel_t [`NUM_NODES-1:0] router_select,
    output noc_alloc_pkg::mesh_mask_t                  router_active,
    output logic [`NUM_NODES-1:0]                      response,
    output noc_alloc_pkg::mesh_mask_t                  port_free
);

    noc_alloc_pkg::mesh_mask_t [`NUM_NODES:0]   claim_chain;  // [n] is seen by node n
    noc_alloc_pkg::grant_t [`NUM_NODES-1:0]     grants;

    route_if routes [`NUM_NODES] ();

    assign claim_chain[0] = '0;

    for (genvar n = 0; n < `NUM_NODES; n++)
    begin : g_node
        route_rom #(
            .SRC (n)
        ) u_route_rom (
            .dest   (dest[n]),
            .routes (routes[n])
        );

        path_arbiter u_path_arbiter (
            .request     (request[n]),
            .routes      (routes[n]),
            .path_free   (path_free),
            .claimed_in  (claim_chain[n]),
            .claimed_out (claim_chain[n+1]),
            .grant       (grants[n])
        );
    end

    router_ctrl_reg u_router_ctrl_reg (
        .clock         (clock),
        .reset         (reset),
        .grants        (grants),
        .router_select (router_select),
        .router_active (router_active),
        .response      (response),
        .port_free     (port_free)
    );

endmodule

`default_nettype wire

//--- testbench/tb_path_alloc.sv
// ----------------------------------------------------------
// directed tests for the 2x2 mesh path allocator
// expected outputs come from a local route model built from
// the path table and mesh geometry; outputs checked one
// cycle after the inputs are driven on the falling edge
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "alloc_defs.svh"

module tb_path_alloc;

    localparam int RAND_CYCLES = 50;
    localparam int TEST_CYCLES = 4 + 2 + 2 + 1 + 1 + RAND_CYCLES;  // reset plus all tests
    localparam int TIMEOUT_NS = (TEST_CYCLES + 40) * 20;

    logic                       clock;
    logic                       reset;
    logic [`NUM_NODES-1:0]      request;
    logic [2*`NUM_NODES-1:0]    dest;       // node n in bits [2n+1:2n]
    logic [`NUM_PATHS-1:0]      path_free;
    logic [59:0]                router_select;
    logic [19:0]                router_active;
    logic [`NUM_NODES-1:0]      response;
    logic [19:0]                port_free;

    // route model, hops listed source router first
    int route_len [`NUM_PATHS];
    int route_hop [`NUM_PATHS][4];
    int pri_path [4][4];
    int alt_path [4][4];    // -1 where there is none

    logic [19:0] exp_active;
    logic [59:0] exp_select;
    logic [3:0]  exp_response;

    int errors;
    int checks;
    int test_errors;

    path_alloc_top DUT (
        .clock         (clock),
        .reset         (reset),
        .request       (request),
        .dest          (dest),
        .path_free     (path_free),
        .router_select (router_select),
        .router_active (router_active),
        .response      (response),
        .port_free     (port_free)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // hops as hex digits, first router in the top digit
    task automatic add_route(input int path, input bit alt, input int n,
                             input logic [15:0] hops);
        int src;
        int dst;
        src = int'(hops[15:12]);
        route_len[path] = n;
        for (int i = 0; i < 4; i++)
            route_hop[path][i] = int'(hops[15-4*i -: 4]);
        dst = route_hop[path][n-1];
        if (alt)
            alt_path[src][dst] = path;
        else
            pri_path[src][dst] = path;
    endtask

    task automatic build_routes();
        for (int s = 0; s < 4; s++)
        begin
            for (int d = 0; d < 4; d++)
            begin
                pri_path[s][d] = -1;
                alt_path[s][d] = -1;
            end
        end
        add_route(0, 0, 1, 16'h0000);
        add_route(1, 0, 2, 16'h0100);
        add_route(2, 1, 4, 16'h0231);
        add_route(3, 0, 2, 16'h0200);
        add_route(4, 1, 4, 16'h0132);
        add_route(5, 0, 3, 16'h0230);
        add_route(6, 1, 3, 16'h0130);
        add_route(7, 0, 1, 16'h1000);
        add_route(8, 0, 2, 16'h1000);
        add_route(9, 1, 4, 16'h1320);
        add_route(10, 0, 2, 16'h1300);
        add_route(11, 1, 4, 16'h1023);
        add_route(12, 0, 3, 16'h1320);
        add_route(13, 1, 3, 16'h1020);
        add_route(14, 0, 1, 16'h2000);
        add_route(15, 0, 2, 16'h2300);
        add_route(16, 1, 4, 16'h2013);
        add_route(17, 0, 2, 16'h2000);
        add_route(18, 1, 4, 16'h2310);
        add_route(19, 0, 3, 16'h2310);
        add_route(20, 1, 3, 16'h2010);
        add_route(21, 0, 1, 16'h3000);
        add_route(22, 0, 2, 16'h3200);
        add_route(23, 1, 4, 16'h3102);
        add_route(24, 0, 2, 16'h3100);
        add_route(25, 1, 4, 16'h3201);
        add_route(26, 0, 3, 16'h3100);
        add_route(27, 1, 3, 16'h3200);
    endtask

    // ports and selects a path claims, from router coordinates
    task automatic route_masks(input int path, output logic [19:0] claim,
                               output logic [59:0] sel);
        int         cur;
        int         nxt;
        int         port;
        logic [2:0] in_sel;
        claim = '0;
        sel = '0;
        in_sel = 3'b100;    // enters from the source processor
        for (int i = 0; i < route_len[path]; i++)
        begin
            cur = route_hop[path][i];
            nxt = (i + 1 < route_len[path]) ? route_hop[path][i+1] : cur;
            if (nxt == cur)
                port = 0;
            else if (nxt % 2 != cur % 2)
                port = (nxt % 2 > cur % 2) ? 2 : 1;    // bit 0 is x
            else
                port = (nxt / 2 > cur / 2) ? 4 : 3;
            claim[cur*5 + port] = 1'b1;
            sel[cur*15 + port*3 +: 3] = in_sel;
            // next router sees the opposite side
            case (port)
                1: in_sel = 3'b010;
                2: in_sel = 3'b011;
                3: in_sel = 3'b000;
                default: in_sel = 3'b001;
            endcase
        end
    endtask

    task automatic model_alloc(input logic [3:0] req, input logic [7:0] dst,
                               input logic [27:0] free);
        logic [19:0] claim;
        logic [59:0] sel;
        int          path;
        exp_active = '0;
        exp_select = '0;
        exp_response = '0;
        for (int n = 0; n < 4; n++)
        begin
            for (int k = 0; k < 2; k++)   // primary first
            begin
                path = (k == 0) ? pri_path[n][dst[2*n +: 2]] : alt_path[n][dst[2*n +: 2]];
                if (req[n] && !exp_response[n] && path >= 0 && free[path])
                begin
                    route_masks(path, claim, sel);
                    if ((claim & exp_active) == '0)
                    begin
                        exp_active = exp_active | claim;
                        exp_select = exp_select | sel;
                        exp_response[n] = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [59:0] expected, input logic [59:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("FAILED %s: %s expected %h actual %h", name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // called at a falling edge, returns at the next one
    task automatic apply_cycle(input string name, input logic [3:0] req,
                               input logic [7:0] dst, input logic [27:0] free);
        logic [19:0] exp_free;
        request = req;
        dest = dst;
        path_free = free;
        model_alloc(req, dst, free);
        exp_free = ~exp_active;
        @(posedge clock);
        @(negedge clock);
        check_value(name, "router_active", 60'(exp_active), 60'(router_active));
        check_value(name, "router_select", exp_select, router_select);
        check_value(name, "response", 60'(exp_response), 60'(response));
        check_value(name, "port_free", 60'(exp_free), 60'(port_free));
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d errors", name, test_errors);
    endtask

    task automatic test_reset_state();
        test_errors = 0;
        check_value("reset_state", "router_active", 60'd0, 60'(router_active));
        check_value("reset_state", "router_select", 60'd0, router_select);
        check_value("reset_state", "response", 60'd0, 60'(response));
        check_value("reset_state", "port_free", 60'(20'hfffff), 60'(port_free));
        apply_cycle("reset_state", 4'b0000, 8'h00, '1);
        report_test("reset_state");
    endtask

    task automatic test_self_route();
        logic [27:0] free;
        test_errors = 0;
        free = '1;
        apply_cycle("self_route", 4'b1000, 8'hc0, free);    // node 3 to itself
        check_value("self_route", "response[3]", 60'd1, 60'(response[3]));
        check_value("self_route", "router 3 proc active", 60'd1, 60'(router_active[15]));
        check_value("self_route", "router 3 proc select", 60'(3'b100),
                    60'(router_select[47:45]));
        free[21] = 1'b0;
        apply_cycle("self_route", 4'b1000, 8'hc0, free);
        check_value("self_route", "response", 60'd0, 60'(response));
        report_test("self_route");
    endtask

    task automatic test_fallback();
        logic [27:0] free;
        test_errors = 0;
        free = '1;
        free[3] = 1'b0;     // direct 0 to 2 blocked
        apply_cycle("fallback", 4'b0001, 8'h02, free);
        check_value("fallback", "response[0]", 60'd1, 60'(response[0]));
        check_value("fallback", "router 0 east active", 60'd1, 60'(router_active[2]));
        report_test("fallback");
    endtask

    task automatic test_priority();
        test_errors = 0;
        apply_cycle("priority", 4'b0011, 8'h0a, '1);   // nodes 0 and 1 both to node 2
        check_value("priority", "response", 60'(4'b0001), 60'(response));
        check_value("priority", "router 2 proc select", 60'(3'b001),
                    60'(router_select[32:30]));
        report_test("priority");
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        logic [27:0] free;
        test_errors = 0;
        for (int i = 0; i < RAND_CYCLES; i++)
        begin
            rnd = $urandom | $urandom;     // mostly free paths
            free = rnd[27:0];
            rnd = $urandom;
            apply_cycle("random", rnd[3:0], rnd[11:4], free);
        end
        report_test("random");
    endtask

    initial
    begin
        errors = 0;
        checks = 0;
        test_errors = 0;
        reset = 1'b1;
        request = '0;
        dest = '0;
        path_free = '0;
        void'($urandom(84));
        build_routes();
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_reset_state();
        test_self_route();
        test_fallback();
        test_priority();
        test_random();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #TIMEOUT_NS;
        $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
verilog/noc_alloc_pkg.sv
verilog/route_if.sv
verilog/route_rom.sv
verilog/path_arbiter.sv
verilog/router_ctrl_reg.sv
verilog/path_alloc_top.sv
testbench/tb_path_alloc.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_path_alloc -o tb_path_alloc
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_path_alloc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
